// File: tb.f
+incdir+logic
logic/mips_isa_pkg.sv
logic/core_pkg.sv
logic/mips_decode.sv
logic/regfile.sv
logic/issue_stage.sv
logic/op_buffer.sv
logic/execute_stage.sv
logic/mips_arith_core.sv
dv/tb_mips_arith_core.sv

// File: Bender.yml
package:
  name: mips_arith_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/mips_isa_pkg.sv
      - logic/core_pkg.sv
      - logic/mips_decode.sv
      - logic/regfile.sv
      - logic/issue_stage.sv
      - logic/op_buffer.sv
      - logic/execute_stage.sv
      - logic/mips_arith_core.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - dv/tb_mips_arith_core.sv

// File: dv/tb_mips_arith_core.sv
`default_nettype none

`include "core_settings.svh"

module tb_mips_arith_core
   import mips_isa_pkg::*;
   import core_pkg::*;
;

   // Rough worst case per instruction, handshakes plus the longest ack delay
   localparam int NUM_INSTS       = 100;
   localparam int CYCLES_PER_INST = 24;
   localparam int WATCHDOG_CYCLES = 16 + NUM_INSTS * CYCLES_PER_INST + 500;

   logic       clk;
   logic       arst_n;
   logic       inst_req;
   word_t      inst;
   logic       inst_ack;
   logic       wb_req;
   wb_report_t wb;
   logic       wb_ack;
   logic       except;

   // Architectural state as the program should see it
   word_t       shadow [`CORE_NUM_REGS];
   // Reports still owed by the DUT, oldest first
   wb_report_t  exp_q [$];
   logic [31:0] rng_state = 32'd22975;

   mips_arith_core i_mips_arith_core (
      .clk      (clk),
      .arst_n   (arst_n),
      .inst_req (inst_req),
      .inst     (inst),
      .inst_ack (inst_ack),
      .wb_req   (wb_req),
      .wb       (wb),
      .wb_ack   (wb_ack),
      .except   (except)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] xorshift();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // Instruction encoders
   function automatic word_t rtype(input logic [5:0] fn, input reg_num_t rs,
                                   input reg_num_t rt, input reg_num_t rd,
                                   input shamt_t sh);
      return {6'h00, rs, rt, rd, sh, fn};
   endfunction

   function automatic word_t itype(input logic [5:0] opc, input reg_num_t rs,
                                   input reg_num_t rt, input imm16_t imm);
      return {opc, rs, rt, imm};
   endfunction

   // Signed compare from the sign bits, then magnitude
   function automatic word_t less_signed(input word_t a, input word_t b);
      if (a[`CORE_XLEN-1] != b[`CORE_XLEN-1]) begin
         return word_t'(a[`CORE_XLEN-1]);
      end else begin
         return word_t'(a < b);
      end
   endfunction

   // Arithmetic right shift built from a logical one
   function automatic word_t shr_arith(input word_t v, input shamt_t n);
      word_t ones;
      ones = '1;
      return (v >> n) | (v[`CORE_XLEN-1] ? ~(ones >> n) : '0);
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Regression failed");
      $fatal(1, "Stopped on the first error");
   endtask

   task automatic check_value(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         abort_run("A DUT output differs from the expected value");
      end
   endtask

   // Reference model from the MIPS semantics
   task automatic predict(input word_t ins, output logic valid, output reg_num_t dest,
                          output word_t value);
      word_t      a;
      word_t      b;
      word_t      se;
      word_t      ze;
      logic [5:0] opc;
      logic [5:0] fn;
      shamt_t     sh;
      opc   = ins[31:26];
      fn    = ins[5:0];
      sh    = ins[10:6];
      a     = shadow[ins[25:21]];
      b     = shadow[ins[20:16]];
      se    = {{(`CORE_XLEN-16){ins[15]}}, ins[15:0]};
      ze    = {{(`CORE_XLEN-16){1'b0}}, ins[15:0]};
      valid = 1'b1;
      dest  = ins[20:16];
      value = '0;
      case (opc)
         OP_RTYPE: begin
            dest = ins[15:11];
            case (fn)
               FN_SLL:          value = b << sh;
               FN_SRL:          value = b >> sh;
               FN_SRA:          value = shr_arith(b, sh);
               FN_SLLV:         value = b << a[4:0];
               FN_SRLV:         value = b >> a[4:0];
               FN_SRAV:         value = shr_arith(b, a[4:0]);
               FN_ADD, FN_ADDU: value = a + b;
               FN_SUB, FN_SUBU: value = a - b;
               FN_AND:          value = a & b;
               FN_OR:           value = a | b;
               FN_XOR:          value = a ^ b;
               FN_NOR:          value = ~(a | b);
               FN_SLT:          value = less_signed(a, b);
               FN_SLTU:         value = word_t'(a < b);
               default:         valid = 1'b0;
            endcase
         end
         OP_ADDI, OP_ADDIU: value = a + se;
         OP_SLTI:           value = less_signed(a, se);
         OP_SLTIU:          value = word_t'(a < se);
         OP_ANDI:           value = a & ze;
         OP_ORI:            value = a | ze;
         OP_XORI:           value = a ^ ze;
         OP_LUI:            value = {ins[15:0], 16'h0000};
         default:           valid = 1'b0;
      endcase
   endtask

   // Four-phase instruction handshake, expected report queued first
   task automatic send_inst(input word_t ins);
      logic       valid;
      reg_num_t   dest;
      word_t      value;
      wb_report_t rep;
      predict(ins, valid, dest, value);
      if (valid) begin
         rep.dest  = dest;
         rep.value = value;
         exp_q.push_back(rep);
         // Register 0 reports its value but keeps zero
         if (dest != '0) begin
            shadow[dest] = value;
         end
      end
      @(negedge clk);
      inst     = ins;
      inst_req = 1'b1;
      @(negedge clk);
      while (!inst_ack) @(negedge clk);
      inst_req = 1'b0;
      @(negedge clk);
      while (inst_ack) @(negedge clk);
   endtask

   // Report side, ack after a random delay of 0 to 5 cycles
   task automatic receive_report();
      wb_report_t exp;
      wb_report_t seen;
      int         delay;
      @(negedge clk);
      while (!wb_req) @(negedge clk);
      if (exp_q.size() == 0) begin
         abort_run("The DUT reported a result that no instruction should produce");
      end else begin
         exp  = exp_q.pop_front();
         seen = wb;
         check_value("wb.dest", word_t'(wb.dest), word_t'(exp.dest));
         check_value("wb.value", wb.value, exp.value);
         delay = int'(xorshift() % 6);
         repeat (delay) begin
            @(negedge clk);
            // Payload held while the request is open
            check_value("wb.value", wb.value, seen.value);
            check_value("wb_req", word_t'(wb_req), word_t'(1'b1));
         end
         wb_ack = 1'b1;
         @(negedge clk);
         while (wb_req) @(negedge clk);
         wb_ack = 1'b0;
      end
   endtask

   task automatic wait_reports_done();
      @(negedge clk);
      while ((exp_q.size() != 0) || wb_req || wb_ack) @(negedge clk);
   endtask

   task automatic load_reg(input reg_num_t r, input word_t v);
      send_inst(itype(OP_LUI, 5'd0, r, v[31:16]));
      send_inst(itype(OP_ORI, r, r, v[15:0]));
   endtask

   task automatic reset_values();
      check_value("inst_ack", word_t'(inst_ack), '0);
      check_value("wb_req", word_t'(wb_req), '0);
      check_value("except", word_t'(except), '0);
   endtask

   task automatic r_type_alu();
      load_reg(5'd1, 32'hFFFF_FFF0);
      load_reg(5'd2, 32'h0000_0025);
      load_reg(5'd3, 32'h8000_0001);
      send_inst(rtype(FN_ADD, 5'd1, 5'd2, 5'd4, 5'd0));
      send_inst(rtype(FN_ADDU, 5'd3, 5'd3, 5'd5, 5'd0));
      send_inst(rtype(FN_SUB, 5'd1, 5'd2, 5'd6, 5'd0));
      send_inst(rtype(FN_SUBU, 5'd2, 5'd1, 5'd7, 5'd0));
      send_inst(rtype(FN_AND, 5'd1, 5'd3, 5'd8, 5'd0));
      send_inst(rtype(FN_OR, 5'd2, 5'd3, 5'd9, 5'd0));
      send_inst(rtype(FN_XOR, 5'd1, 5'd2, 5'd10, 5'd0));
      send_inst(rtype(FN_NOR, 5'd1, 5'd2, 5'd11, 5'd0));
      // Negative against positive, signed and unsigned disagree
      send_inst(rtype(FN_SLT, 5'd1, 5'd2, 5'd12, 5'd0));
      send_inst(rtype(FN_SLTU, 5'd1, 5'd2, 5'd13, 5'd0));
      send_inst(rtype(FN_SLT, 5'd2, 5'd1, 5'd14, 5'd0));
      send_inst(rtype(FN_SLTU, 5'd2, 5'd1, 5'd15, 5'd0));
      wait_reports_done();
   endtask

   task automatic immediates();
      load_reg(5'd1, 32'h0000_1234);
      send_inst(itype(OP_ADDI, 5'd1, 5'd2, 16'hFFFE));
      send_inst(itype(OP_ADDIU, 5'd0, 5'd3, 16'h8000));
      send_inst(itype(OP_SLTI, 5'd3, 5'd4, 16'h0001));
      // Positive value against a negative immediate
      send_inst(itype(OP_SLTI, 5'd1, 5'd11, 16'h8000));
      send_inst(itype(OP_SLTIU, 5'd3, 5'd5, 16'hFFFF));
      send_inst(itype(OP_SLTIU, 5'd3, 5'd6, 16'h0005));
      // Zero extension on the logical ops
      send_inst(itype(OP_ANDI, 5'd3, 5'd7, 16'hF0F0));
      send_inst(itype(OP_ORI, 5'd1, 5'd8, 16'h8001));
      send_inst(itype(OP_XORI, 5'd1, 5'd9, 16'hFFFF));
      send_inst(itype(OP_LUI, 5'd0, 5'd10, 16'hBEEF));
      wait_reports_done();
   endtask

   task automatic shifts();
      load_reg(5'd1, 32'h8765_4321);
      send_inst(rtype(FN_SLL, 5'd0, 5'd1, 5'd2, 5'd4));
      send_inst(rtype(FN_SRL, 5'd0, 5'd1, 5'd3, 5'd8));
      send_inst(rtype(FN_SRA, 5'd0, 5'd1, 5'd4, 5'd8));
      send_inst(rtype(FN_SRA, 5'd0, 5'd1, 5'd5, 5'd0));
      // Only the low five bits of rs count
      load_reg(5'd6, 32'h0000_0024);
      send_inst(rtype(FN_SLLV, 5'd6, 5'd1, 5'd7, 5'd0));
      send_inst(rtype(FN_SRLV, 5'd6, 5'd1, 5'd8, 5'd0));
      send_inst(rtype(FN_SRAV, 5'd6, 5'd1, 5'd9, 5'd0));
      send_inst(itype(OP_ORI, 5'd0, 5'd10, 16'd31));
      send_inst(rtype(FN_SRAV, 5'd10, 5'd1, 5'd11, 5'd0));
      wait_reports_done();
   endtask

   task automatic dependent_chain();
      logic [31:0] rnd;
      send_inst(itype(OP_ORI, 5'd0, 5'd1, 16'd5));
      send_inst(itype(OP_ORI, 5'd0, 5'd2, 16'd7));
      // Each result feeds the next two
      for (int i = 0; i < 8; i++) begin
         send_inst(rtype(FN_ADDU, reg_num_t'(i + 1), reg_num_t'(i + 2),
                         reg_num_t'(i + 3), 5'd0));
      end
      // Independent writes fill the buffer behind a slow ack
      for (int i = 0; i < 8; i++) begin
         rnd = xorshift();
         send_inst(itype(OP_ORI, 5'd0, reg_num_t'(20 + i), rnd[15:0]));
      end
      send_inst(rtype(FN_SUB, 5'd20, 5'd10, 5'd28, 5'd0));
      // Write to register 0, then read it back as zero
      send_inst(rtype(FN_ADDU, 5'd9, 5'd10, 5'd0, 5'd0));
      // The write reaches the register file before the read
      wait_reports_done();
      send_inst(rtype(FN_ADDU, 5'd0, 5'd10, 5'd11, 5'd0));
      send_inst(rtype(FN_SUB, 5'd0, 5'd9, 5'd12, 5'd0));
      wait_reports_done();
   endtask

   task automatic unknown_insts();
      load_reg(5'd1, 32'h0000_0040);
      wait_reports_done();
      check_value("except", word_t'(except), '0);
      // Lw, beq and j are not part of this core
      send_inst(itype(6'h23, 5'd1, 5'd2, 16'h0004));
      check_value("except", word_t'(except), 32'd1);
      send_inst(itype(6'h04, 5'd1, 5'd1, 16'h0010));
      send_inst({6'h02, 26'h000_0100});
      send_inst(rtype(6'h08, 5'd1, 5'd0, 5'd0, 5'd0));
      // Execution continues after them
      send_inst(itype(OP_ADDIU, 5'd1, 5'd2, 16'hFFF0));
      send_inst(rtype(FN_XOR, 5'd1, 5'd2, 5'd3, 5'd0));
      wait_reports_done();
      check_value("except", word_t'(except), 32'd1);
   endtask

   // Report side runs on its own
   initial begin
      forever receive_report();
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      abort_run("Watchdog expired before the tests completed");
   end

   initial begin
      arst_n   = 1'b0;
      inst_req = 1'b0;
      inst     = '0;
      wb_ack   = 1'b0;
      for (int i = 0; i < `CORE_NUM_REGS; i++) begin
         shadow[i] = '0;
      end
      repeat (16) @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      reset_values();
      r_type_alu();
      immediates();
      shifts();
      dependent_chain();
      unknown_insts();
      // No stray report may follow
      repeat (10) @(negedge clk);
      check_value("wb_req", word_t'(wb_req), '0);
      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: logic/mips_arith_core.sv
`default_nettype none

module mips_arith_core
   import mips_isa_pkg::*;
   import core_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  logic       inst_req,
   input  word_t      inst,
   output logic       inst_ack,
   output logic       wb_req,
   output wb_report_t wb,
   input  logic       wb_ack,
   output logic       except
);

   // Issue to buffer
   exec_op_t issue_op;
   logic     push;
   logic     buf_full;
   // Buffer to execute
   exec_op_t exec_op;
   logic     pop;
   logic     buf_empty;
   // Register file ports
   reg_num_t rs_num;
   reg_num_t rt_num;
   word_t    rs_data;
   word_t    rt_data;
   // Write port, also seen by the scoreboard
   reg_num_t wr_num;
   word_t    wr_data;
   logic     wr_en;

   issue_stage i_issue_stage (
      .clk      (clk),
      .arst_n   (arst_n),
      .inst_req (inst_req),
      .inst     (inst),
      .buf_full (buf_full),
      .rs_data  (rs_data),
      .rt_data  (rt_data),
      .wr_num   (wr_num),
      .wr_en    (wr_en),
      .inst_ack (inst_ack),
      .rs_num   (rs_num),
      .rt_num   (rt_num),
      .push     (push),
      .op       (issue_op),
      .except   (except)
   );

   op_buffer i_op_buffer (
      .clk    (clk),
      .arst_n (arst_n),
      .push   (push),
      .din    (issue_op),
      .pop    (pop),
      .dout   (exec_op),
      .full   (buf_full),
      .empty  (buf_empty)
   );

   regfile i_regfile (
      .clk     (clk),
      .arst_n  (arst_n),
      .rs_num  (rs_num),
      .rt_num  (rt_num),
      .rd_num  (wr_num),
      .rd_data (wr_data),
      .rd_we   (wr_en),
      .rs_data (rs_data),
      .rt_data (rt_data)
   );

   execute_stage i_execute_stage (
      .clk     (clk),
      .arst_n  (arst_n),
      .op      (exec_op),
      .empty   (buf_empty),
      .wb_ack  (wb_ack),
      .pop     (pop),
      .wr_num  (wr_num),
      .wr_data (wr_data),
      .wr_en   (wr_en),
      .wb_req  (wb_req),
      .wb      (wb)
   );

endmodule

`default_nettype wire

// File: logic/execute_stage.sv
`default_nettype none

`include "core_settings.svh"

module execute_stage
   import mips_isa_pkg::*;
   import core_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  exec_op_t   op,
   input  logic       empty,
   input  logic       wb_ack,
   output logic       pop,
   output reg_num_t   wr_num,
   output word_t      wr_data,
   output logic       wr_en,
   output logic       wb_req,
   output wb_report_t wb
);

   typedef enum logic [1:0] {
      EX_IDLE,
      EX_REQ,
      EX_RELEASE
   } exec_state_e;

   exec_state_e state_q;
   word_t       alu_res;
   word_t       shift_res;
   word_t       result;

   // ALU
   always_comb begin
      alu_res = op.a + op.b;
      case (op.alu_op)
         ALU_SUB:  alu_res = op.a - op.b;
         ALU_AND:  alu_res = op.a & op.b;
         ALU_OR:   alu_res = op.a | op.b;
         ALU_XOR:  alu_res = op.a ^ op.b;
         ALU_NOR:  alu_res = ~(op.a | op.b);
         ALU_SLT:  alu_res = word_t'($signed(op.a) < $signed(op.b));
         ALU_SLTU: alu_res = word_t'(op.a < op.b);
         default:  alu_res = op.a + op.b;
      endcase
   end

   // Shifter, the shifted value is rt in operand b
   always_comb begin
      case (op.shift_op)
         SHIFT_RIGHT_LOGICAL:    shift_res = op.b >> op.shamt;
         SHIFT_RIGHT_ARITHMETIC: shift_res = $signed(op.b) >>> op.shamt;
         default:                shift_res = op.b << op.shamt;
      endcase
   end

   // Write-back select
   always_comb begin
      case (op.wb_sel)
         WB_SHIFT: result = shift_res;
         WB_LUI:   result = {op.imm, {(`CORE_XLEN-16){1'b0}}};
         default:  result = alu_res;
      endcase
   end

   // Take the next op only when the previous report has closed
   assign pop     = (state_q == EX_IDLE) && !empty;
   assign wr_en   = pop;
   assign wr_num  = op.dest;
   assign wr_data = result;

   // Report handshake FSM
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= EX_IDLE;
         wb_req  <= 1'b0;
      end else begin
         case (state_q)
            EX_IDLE: begin
               if (pop) begin
                  state_q <= EX_REQ;
                  wb_req  <= 1'b1;
               end
            end
            EX_REQ: begin
               if (wb_ack) begin
                  state_q <= EX_RELEASE;
                  wb_req  <= 1'b0;
               end
            end
            // Wait for ack low
            EX_RELEASE: begin
               if (!wb_ack) begin
                  state_q <= EX_IDLE;
               end
            end
            default: state_q <= EX_IDLE;
         endcase
      end
   end

   // Report payload, captured on the pop
   always_ff @(posedge clk) begin
      if (pop) begin
         wb.dest  <= op.dest;
         wb.value <= result;
      end
   end

   a_wb_stable: assert property (@(posedge clk) disable iff (!arst_n)
      (wb_req && !wb_ack) |=> $stable(wb));

endmodule

`default_nettype wire

// File: logic/op_buffer.sv
`default_nettype none

`include "core_settings.svh"

module op_buffer
   import core_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  logic     push,
   input  exec_op_t din,
   input  logic     pop,
   output exec_op_t dout,
   output logic     full,
   output logic     empty
);

   localparam int unsigned DEPTH = `CORE_OPBUF_DEPTH;
   localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int unsigned CNT_W = $clog2(DEPTH + 1);

   exec_op_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;

   // Pointers wrap at DEPTH, which need not be a power of two
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // Storage
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr_q] <= din;
      end
   end

   // Head entry visible without a pop
   assign dout  = mem[rd_ptr_q];
   assign full  = (count_q == CNT_W'(DEPTH));
   assign empty = (count_q == '0);

   a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n) !(push && full));
   a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n) !(pop && empty));

endmodule

`default_nettype wire

// File: logic/issue_stage.sv
`default_nettype none

`include "core_settings.svh"

module issue_stage
   import mips_isa_pkg::*;
   import core_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  logic     inst_req,
   input  word_t    inst,
   input  logic     buf_full,
   input  word_t    rs_data,
   input  word_t    rt_data,
   input  reg_num_t wr_num,
   input  logic     wr_en,
   output logic     inst_ack,
   output reg_num_t rs_num,
   output reg_num_t rt_num,
   output logic     push,
   output exec_op_t op,
   output logic     except
);

   typedef enum logic {
      IS_IDLE,
      IS_RELEASE
   } issue_state_e;

   issue_state_e              state_q;
   decode_t                   dec;
   reg_num_t                  rd_num;
   reg_num_t                  dest;
   imm16_t                    imm;
   word_t                     imm_ext;
   logic [`CORE_NUM_REGS-1:0] busy_q;
   logic                      stall;
   logic                      accept;

   mips_decode i_mips_decode (
      .inst (inst),
      .dec  (dec)
   );

   // Instruction fields
   assign rs_num = inst[25:21];
   assign rt_num = inst[20:16];
   assign rd_num = inst[15:11];
   assign imm    = inst[15:0];
   // I-types write rt, R-types write rd
   assign dest   = dec.use_imm ? rt_num : rd_num;

   assign imm_ext = dec.sign_ext ? {{(`CORE_XLEN-16){imm[15]}}, imm}
                                 : {{(`CORE_XLEN-16){1'b0}}, imm};

   // Wait on pending sources
   // A pending destination also stalls so that an older write cannot clear a newer busy bit
   assign stall = busy_q[rs_num] | (dec.reads_rt & busy_q[rt_num]) | busy_q[dest] | buf_full;

   // Unrecognized instructions are taken without waiting
   assign accept = (state_q == IS_IDLE) && inst_req && (dec.except || !stall);
   assign push   = accept && !dec.except;

   always_comb begin
      op.alu_op   = dec.alu_op;
      op.shift_op = dec.shift_op;
      op.wb_sel   = dec.wb_sel;
      op.a        = rs_data;
      op.b        = dec.use_imm ? imm_ext : rt_data;
      op.shamt    = dec.shift_v ? rs_data[$bits(shamt_t)-1:0] : inst[10:6];
      op.imm      = imm;
      op.dest     = dest;
   end

   // Handshake FSM, ack is held until req falls
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q  <= IS_IDLE;
         inst_ack <= 1'b0;
         except   <= 1'b0;
      end else begin
         case (state_q)
            IS_IDLE: begin
               if (accept) begin
                  state_q  <= IS_RELEASE;
                  inst_ack <= 1'b1;
                  // Sticky until reset
                  if (dec.except) begin
                     except <= 1'b1;
                  end
               end
            end
            IS_RELEASE: begin
               if (!inst_req) begin
                  state_q  <= IS_IDLE;
                  inst_ack <= 1'b0;
               end
            end
         endcase
      end
   end

   // Scoreboard
   // Bit 0 is never set
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         busy_q <= '0;
      end else begin
         if (wr_en) begin
            busy_q[wr_num] <= 1'b0;
         end
         if (push && (dest != '0)) begin
            busy_q[dest] <= 1'b1;
         end
      end
   end

   a_ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(inst_ack) |-> $past(inst_req));

endmodule

`default_nettype wire

// File: logic/regfile.sv
`default_nettype none

`include "core_settings.svh"

module regfile
   import mips_isa_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  reg_num_t rs_num,
   input  reg_num_t rt_num,
   input  reg_num_t rd_num,
   input  word_t    rd_data,
   input  logic     rd_we,
   output word_t    rs_data,
   output word_t    rt_data
);

   word_t regs [`CORE_NUM_REGS];

   // Register 0 is never written, so it stays at its reset value of zero
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `CORE_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (rd_we && (rd_num != '0)) begin
         regs[rd_num] <= rd_data;
      end
   end

   // Combinational read ports
   assign rs_data = regs[rs_num];
   assign rt_data = regs[rt_num];

endmodule

`default_nettype wire

// File: logic/mips_decode.sv
`default_nettype none

module mips_decode
   import mips_isa_pkg::*;
   import core_pkg::*;
(
   input  word_t   inst,
   output decode_t dec
);

   logic [5:0] opcode;
   logic [5:0] funct;

   assign opcode = inst[31:26];
   assign funct  = inst[5:0];

   always_comb begin
      // Defaults give an add with register operands
      dec          = '0;
      dec.alu_op   = ALU_ADD;
      dec.shift_op = SHIFT_LEFT;
      dec.wb_sel   = WB_ALU;

      case (opcode)
         OP_RTYPE: begin
            dec.reads_rt = 1'b1;
            case (funct)
               // Constant shifts take shamt
               FN_SLL: begin
                  dec.wb_sel = WB_SHIFT;
               end
               FN_SRL: begin
                  dec.wb_sel   = WB_SHIFT;
                  dec.shift_op = SHIFT_RIGHT_LOGICAL;
               end
               FN_SRA: begin
                  dec.wb_sel   = WB_SHIFT;
                  dec.shift_op = SHIFT_RIGHT_ARITHMETIC;
               end
               // Variable shifts take the amount from rs
               FN_SLLV: begin
                  dec.wb_sel  = WB_SHIFT;
                  dec.shift_v = 1'b1;
               end
               FN_SRLV: begin
                  dec.wb_sel   = WB_SHIFT;
                  dec.shift_v  = 1'b1;
                  dec.shift_op = SHIFT_RIGHT_LOGICAL;
               end
               FN_SRAV: begin
                  dec.wb_sel   = WB_SHIFT;
                  dec.shift_v  = 1'b1;
                  dec.shift_op = SHIFT_RIGHT_ARITHMETIC;
               end
               // No overflow trap, add and addu are the same
               FN_ADD, FN_ADDU: dec.alu_op = ALU_ADD;
               FN_SUB, FN_SUBU: dec.alu_op = ALU_SUB;
               FN_AND:  dec.alu_op = ALU_AND;
               FN_OR:   dec.alu_op = ALU_OR;
               FN_XOR:  dec.alu_op = ALU_XOR;
               FN_NOR:  dec.alu_op = ALU_NOR;
               FN_SLT:  dec.alu_op = ALU_SLT;
               FN_SLTU: dec.alu_op = ALU_SLTU;
               // Jr, jalr and anything else
               default: dec.except = 1'b1;
            endcase
         end
         // Sign-extended immediates
         OP_ADDI, OP_ADDIU: begin
            dec.use_imm  = 1'b1;
            dec.sign_ext = 1'b1;
         end
         OP_SLTI: begin
            dec.use_imm  = 1'b1;
            dec.sign_ext = 1'b1;
            dec.alu_op   = ALU_SLT;
         end
         // Extended as signed, compared as unsigned
         OP_SLTIU: begin
            dec.use_imm  = 1'b1;
            dec.sign_ext = 1'b1;
            dec.alu_op   = ALU_SLTU;
         end
         // Logical immediates are zero-extended
         OP_ANDI: begin
            dec.use_imm = 1'b1;
            dec.alu_op  = ALU_AND;
         end
         OP_ORI: begin
            dec.use_imm = 1'b1;
            dec.alu_op  = ALU_OR;
         end
         OP_XORI: begin
            dec.use_imm = 1'b1;
            dec.alu_op  = ALU_XOR;
         end
         OP_LUI: begin
            dec.use_imm = 1'b1;
            dec.wb_sel  = WB_LUI;
         end
         // Loads, stores, branches and jumps
         default: dec.except = 1'b1;
      endcase
   end

endmodule

`default_nettype wire

// File: logic/core_pkg.sv
`default_nettype none

package core_pkg;

   import mips_isa_pkg::*;

   // ALU function, slt signed and sltu unsigned
   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NOR,
      ALU_SLT,
      ALU_SLTU
   } alu_op_e;

   typedef enum logic [1:0] {
      SHIFT_LEFT,
      SHIFT_RIGHT_LOGICAL,
      SHIFT_RIGHT_ARITHMETIC
   } shift_op_e;

   // Source of the write-back value
   typedef enum logic [1:0] {
      WB_ALU,
      WB_SHIFT,
      WB_LUI
   } wb_sel_e;

   // Control produced by the decoder
   typedef struct packed {
      alu_op_e   alu_op;
      shift_op_e shift_op;
      wb_sel_e   wb_sel;
      // Operand b from the immediate, destination is rt
      logic      use_imm;
      logic      sign_ext;
      // Shift amount from rs instead of shamt
      logic      shift_v;
      logic      reads_rt;
      logic      except;
   } decode_t;

   // One operation ready to execute, operands already read
   typedef struct packed {
      alu_op_e   alu_op;
      shift_op_e shift_op;
      wb_sel_e   wb_sel;
      word_t     a;
      word_t     b;
      shamt_t    shamt;
      imm16_t    imm;
      reg_num_t  dest;
   } exec_op_t;

   // One reported result
   typedef struct packed {
      reg_num_t dest;
      word_t    value;
   } wb_report_t;

endpackage

`default_nettype wire

// File: logic/mips_isa_pkg.sv
`default_nettype none

`include "core_settings.svh"

package mips_isa_pkg;

   // Data or instruction word
   typedef logic [`CORE_XLEN-1:0] word_t;
   // Register number, rs, rt and rd fields
   typedef logic [$clog2(`CORE_NUM_REGS)-1:0] reg_num_t;
   typedef logic [4:0] shamt_t;
   typedef logic [15:0] imm16_t;

   // Major opcode in inst[31:26]
   // Only the arithmetic I-types are kept, 0 selects R-type
   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,
      OP_ADDI  = 6'h08,
      OP_ADDIU = 6'h09,
      OP_SLTI  = 6'h0a,
      OP_SLTIU = 6'h0b,
      OP_ANDI  = 6'h0c,
      OP_ORI   = 6'h0d,
      OP_XORI  = 6'h0e,
      OP_LUI   = 6'h0f
   } opcode_e;

   // Funct field in inst[5:0] for R-type
   typedef enum logic [5:0] {
      FN_SLL  = 6'h00,
      FN_SRL  = 6'h02,
      FN_SRA  = 6'h03,
      FN_SLLV = 6'h04,
      FN_SRLV = 6'h06,
      FN_SRAV = 6'h07,
      FN_ADD  = 6'h20,
      FN_ADDU = 6'h21,
      FN_SUB  = 6'h22,
      FN_SUBU = 6'h23,
      FN_AND  = 6'h24,
      FN_OR   = 6'h25,
      FN_XOR  = 6'h26,
      FN_NOR  = 6'h27,
      FN_SLT  = 6'h2a,
      FN_SLTU = 6'h2b
   } funct_e;

endpackage

`default_nettype wire

// File: logic/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Width of a data word and of an instruction
`define CORE_XLEN 32

// Architectural registers, register 0 reads as zero
`define CORE_NUM_REGS 32

// Decoded operations held between issue and execute
`define CORE_OPBUF_DEPTH 4

`endif
